// ==== sim.f ====
source/loader_pkg.sv
source/mem_slot_if.sv
source/download_loader.sv
source/tape_reader.sv
source/mem_slot_arbiter.sv
source/c64_media_loader.sv
testbench/tb_clock_gen.sv
testbench/c64_media_loader_sva.sv
testbench/tb_c64_media_loader.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_c64_media_loader
FILELIST  = sim.f
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(SIM_BIN) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== testbench/tb_c64_media_loader.sv ====
//================================================
// Media loader testbench
// Table driven downloads, tape playback and reset checks
//================================================
`timescale 1ns/1ps

module tb_c64_media_loader
	import loader_pkg::*;
;

	// Mode 0 checks playback at once, 1 overlaps it with the next download,
	// 2 adds pause and full, 3 unloads the tape
	typedef struct packed {
		byte_t       idx;
		logic [15:0] load;
		logic [7:0]  cnt;
		addr_t       base;
		logic [1:0]  mode;
	} test_t;

	localparam int NUM_TESTS = 5;

	test_t tests [NUM_TESTS] = '{
		'{IDX_PRG, 16'h0801, 8'd12, 25'h000801, 2'd0},
		'{IDX_TAP, 16'h0000, 8'd20, TAP_BASE,   2'd1},
		'{IDX_PRG, 16'hc000, 8'd8,  25'h00c000, 2'd0},
		'{IDX_TAP, 16'h0000, 8'd24, TAP_BASE,   2'd2},
		'{IDX_TAP, 16'h0000, 8'd16, TAP_BASE,   2'd3}
	};

	logic  clk_sys;
	logic  reset_n;
	logic  dl_active_i;
	byte_t dl_index_i;
	logic  dl_wr_i;
	addr_t dl_addr_i;
	byte_t dl_data_i;
	logic  dl_wait_o;
	logic  tap_play_btn_i;
	logic  tap_unload_i;
	logic  tap_full_i;
	logic  tap_byte_valid_o;
	byte_t tap_byte_o;
	logic  tap_playing_o;
	logic  mem_slot_i;
	logic  mem_ce_o;
	logic  mem_we_o;
	addr_t mem_addr_o;
	byte_t mem_wdata_o;
	byte_t mem_rdata_i;

	byte_t       mem [addr_t];
	byte_t       exp_q[$];
	byte_t       tape_exp[$];
	byte_t       tap_q[$];
	logic [31:0] lcg_state = 32'h40b;
	logic [2:0]  slot_cnt = '0;
	logic        wr_d = 1'b0;
	int          wr_count = 0;
	int          cycles = 0;
	int          cycle_limit = 2000;
	int          errors = 0;
	int          checks = 0;
	int          tests_done = 0;

	tb_clock_gen i_tb_clock_gen (
		.clk_sys_o (clk_sys),
		.reset_n_o (reset_n)
	);

	c64_media_loader i_c64_media_loader (.*);

	//================================================
	// Memory model, window and monitors
	//================================================

	// Unwritten bytes read back a pattern of the full address
	function automatic byte_t peek(input addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]} ^ 8'h5a;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	always @(posedge clk_sys) begin
		if (mem_ce_o && mem_we_o) begin
			mem[mem_addr_o] = mem_wdata_o;
			if (!wr_d)
				wr_count++;
		end
		wr_d = mem_ce_o && mem_we_o;
		if (reset_n && tap_byte_valid_o)
			tap_q.push_back(tap_byte_o);
	end

	// Window high for 3 clocks out of 8
	always @(negedge clk_sys) begin
		slot_cnt    = slot_cnt + 3'd1;
		mem_slot_i  = (slot_cnt < 3'd3);
		mem_rdata_i = peek(mem_addr_o);
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	//================================================
	// Checks and stimulus tasks
	//================================================

	task automatic check_eq(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic download(input test_t t);
		byte_t b;
		int    hdr;
		int    wr_start;
		int    waited;
		hdr      = (t.idx == IDX_PRG) ? PRG_HDR_LEN : 0;
		wr_start = wr_count;
		exp_q.delete();
		@(negedge clk_sys);
		dl_active_i = 1'b1;
		dl_index_i  = t.idx;
		for (int k = 0; k < hdr + int'(t.cnt); k++) begin
			if (k < hdr) begin
				b = (k == 0) ? t.load[7:0] : t.load[15:8];
			end else begin
				lcg_state = lcg_next(lcg_state);
				b         = lcg_state[23:16];
				exp_q.push_back(b);
			end
			dl_wr_i   = 1'b1;
			dl_addr_i = addr_t'(k);
			dl_data_i = b;
			@(negedge clk_sys);
			dl_wr_i = 1'b0;
			check_eq("dl_wait_o after byte", 32'(dl_wait_o), 32'(k >= hdr));
			// Loader takes the very next window, even against a tape read
			waited = 0;
			while (dl_wait_o) begin
				@(negedge clk_sys);
				waited++;
			end
			check_eq("dl_wait_o within one window", 32'(waited <= 8), 1);
		end
		dl_active_i = 1'b0;
		repeat (16) @(negedge clk_sys);
		check_eq("write count", wr_count - wr_start, 32'(t.cnt));
		for (int n = 0; n < int'(t.cnt); n++)
			check_eq("memory byte", 32'(peek(t.base + addr_t'(n))), 32'(exp_q[n]));
	endtask

	task automatic pulse_play;
		tap_play_btn_i = 1'b1;
		@(negedge clk_sys);
		tap_play_btn_i = 1'b0;
	endtask

	task automatic wait_strobes(input int n);
		int waited;
		waited = 0;
		while (tap_q.size() < n && waited < 400) begin
			@(negedge clk_sys);
			waited++;
		end
	endtask

	task automatic finish_tape;
		wait_strobes(tape_exp.size());
		if (tap_q.size() < tape_exp.size()) begin
			errors++;
			$display("Tape playback stopped after %0d of %0d bytes",
				tap_q.size(), tape_exp.size());
		end
		repeat (48) @(negedge clk_sys);
		check_eq("tape strobe count", tap_q.size(), tape_exp.size());
		for (int n = 0; n < tape_exp.size() && n < tap_q.size(); n++)
			check_eq("tape byte", 32'(tap_q[n]), 32'(tape_exp[n]));
		tap_q.delete();
		$display("Tape playback checked, %0d bytes", tape_exp.size());
	endtask

	// Play button and full input hold back the strobes
	task automatic pause_and_full;
		int n0;
		int n1;
		wait_strobes(3);
		pulse_play();
		check_eq("tap_playing_o after pause", 32'(tap_playing_o), 0);
		n0 = tap_q.size();
		repeat (64) @(negedge clk_sys);
		n1 = tap_q.size();
		check_eq("strobes after pause", 32'(n1 <= n0 + 1), 1);
		repeat (64) @(negedge clk_sys);
		check_eq("strobes while paused", tap_q.size(), n1);
		pulse_play();
		check_eq("tap_playing_o after resume", 32'(tap_playing_o), 1);
		wait_strobes(n1 + 1);
		check_eq("strobe after resume", 32'(tap_q.size() > n1), 1);
		tap_full_i = 1'b1;
		n0 = tap_q.size();
		repeat (64) @(negedge clk_sys);
		n1 = tap_q.size();
		check_eq("strobes after full", 32'(n1 <= n0 + 1), 1);
		repeat (64) @(negedge clk_sys);
		check_eq("strobes while full", tap_q.size(), n1);
		tap_full_i = 1'b0;
	endtask

	task automatic unload_tape;
		int n0;
		wait_strobes(2);
		tap_unload_i = 1'b1;
		@(negedge clk_sys);
		tap_unload_i = 1'b0;
		n0 = tap_q.size();
		check_eq("tap_playing_o after unload", 32'(tap_playing_o), 0);
		repeat (100) @(negedge clk_sys);
		check_eq("strobes after unload", tap_q.size(), n0);
		tap_q.delete();
	endtask

	task automatic check_idle_outputs;
		check_eq("mem_ce_o in reset", 32'(mem_ce_o), 0);
		check_eq("mem_we_o in reset", 32'(mem_we_o), 0);
		check_eq("dl_wait_o in reset", 32'(dl_wait_o), 0);
		check_eq("tap_byte_valid_o in reset", 32'(tap_byte_valid_o), 0);
		check_eq("tap_playing_o in reset", 32'(tap_playing_o), 0);
	endtask

	//================================================
	// Main sequence
	//================================================

	initial begin
		dl_active_i    = 1'b0;
		dl_index_i     = '0;
		dl_wr_i        = 1'b0;
		dl_addr_i      = '0;
		dl_data_i      = '0;
		tap_play_btn_i = 1'b0;
		tap_unload_i   = 1'b0;
		tap_full_i     = 1'b0;
		mem_slot_i     = 1'b0;
		mem_rdata_i    = '0;
		for (int i = 0; i < NUM_TESTS; i++)
			cycle_limit += 16 * int'(tests[i].cnt);

		@(negedge clk_sys);
		while (!reset_n) begin
			check_idle_outputs();
			@(negedge clk_sys);
		end
		repeat (4) begin
			check_idle_outputs();
			@(negedge clk_sys);
		end
		tests_done++;
		$display("Reset test done");

		for (int i = 0; i < NUM_TESTS; i++) begin
			download(tests[i]);
			if (tests[i].idx == IDX_TAP) begin
				tape_exp = exp_q;
				tape_exp.push_back(peek(TAP_BASE + addr_t'(tests[i].cnt)));
				case (tests[i].mode)
					2'd0: finish_tape();
					2'd2: begin
						pause_and_full();
						finish_tape();
					end
					2'd3: unload_tape();
					default: ;
				endcase
			end else if (tape_exp.size() != 0) begin
				// Program download ran alongside playback
				finish_tape();
				tape_exp.delete();
			end
			tests_done++;
			$display("Test %0d done, index %0d, %0d bytes", i, tests[i].idx, tests[i].cnt);
		end

		$display("Tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== testbench/c64_media_loader_sva.sv ====
//================================================
// Memory cycle and slot rule assertions
//================================================
`timescale 1ns/1ps

module c64_media_loader_sva (
	input logic clk_sys,
	input logic reset_n,
	input logic mem_slot_i,
	input logic mem_ce_i,
	input logic mem_we_i,
	input logic ld_ack_i,
	input logic tp_ack_i
);

	// A write strobe needs an active cycle
	a_we_needs_ce: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_i |-> mem_ce_i)
		else $error("mem_we_o high without mem_ce_o");

	// Cycle ends only on the second high sample of the window
	a_ce_fall_in_window: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$fell(mem_ce_i) |-> ($past(mem_slot_i, 1) && $past(mem_slot_i, 2)))
		else $error("mem_ce_o fell before two high window samples");

	// One client per grant, and only once the previous cycle has closed
	a_single_ack: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(ld_ack_i || tp_ack_i) |-> (!(ld_ack_i && tp_ack_i) && !mem_ce_i))
		else $error("acknowledge to both clients or while a memory cycle is open");

endmodule

bind mem_slot_arbiter c64_media_loader_sva i_c64_media_loader_sva (
	.clk_sys    (clk_sys),
	.reset_n    (reset_n),
	.mem_slot_i (mem_slot_i),
	.mem_ce_i   (mem_ce_o),
	.mem_we_i   (mem_we_o),
	.ld_ack_i   (ld.ack),
	.tp_ack_i   (tp.ack)
);

// ==== testbench/tb_clock_gen.sv ====
//================================================
// Testbench clock and reset
//================================================
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys_o,
	output logic reset_n_o
);

	localparam time HALF_PERIOD = 20ns;

	initial begin
		clk_sys_o = 1'b0;
		forever #(HALF_PERIOD) clk_sys_o = ~clk_sys_o;
	end

	// Reset held for five clocks, released on a falling edge
	initial begin
		reset_n_o = 1'b0;
		repeat (5) @(posedge clk_sys_o);
		@(negedge clk_sys_o);
		reset_n_o = 1'b1;
	end

endmodule

// ==== source/c64_media_loader.sv ====
//================================================
// Media loading path top level
// Download loader and tape reader share the memory window
//================================================
`timescale 1ns/1ps

module c64_media_loader
	import loader_pkg::*;
(
	input  logic  clk_sys,
	input  logic  reset_n,

	// Host download
	input  logic  dl_active_i,
	input  byte_t dl_index_i,
	input  logic  dl_wr_i,
	input  addr_t dl_addr_i,
	input  byte_t dl_data_i,
	output logic  dl_wait_o,

	// Tape playback
	input  logic  tap_play_btn_i,
	input  logic  tap_unload_i,
	input  logic  tap_full_i,
	output logic  tap_byte_valid_o,
	output byte_t tap_byte_o,
	output logic  tap_playing_o,

	// Memory window
	input  logic  mem_slot_i,
	output logic  mem_ce_o,
	output logic  mem_we_o,
	output addr_t mem_addr_o,
	output byte_t mem_wdata_o,
	input  byte_t mem_rdata_i
);

	mem_slot_if ld_slot ();
	mem_slot_if tp_slot ();

	download_loader i_download_loader (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_wait_o   (dl_wait_o),
		.slot        (ld_slot.client)
	);

	tape_reader i_tape_reader (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.dl_active_i      (dl_active_i),
		.dl_index_i       (dl_index_i),
		.dl_wr_i          (dl_wr_i),
		.dl_addr_i        (dl_addr_i),
		.tap_play_btn_i   (tap_play_btn_i),
		.tap_unload_i     (tap_unload_i),
		.tap_full_i       (tap_full_i),
		.tap_byte_valid_o (tap_byte_valid_o),
		.tap_byte_o       (tap_byte_o),
		.tap_playing_o    (tap_playing_o),
		.slot             (tp_slot.client)
	);

	// Loader write wins over a tape read in the same window
	mem_slot_arbiter i_mem_slot_arbiter (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.ld          (ld_slot.arbiter),
		.tp          (tp_slot.arbiter),
		.mem_slot_i  (mem_slot_i),
		.mem_ce_o    (mem_ce_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_rdata_i (mem_rdata_i)
	);

endmodule

// ==== source/mem_slot_arbiter.sv ====
//================================================
// Memory slot arbiter
// One memory cycle per free window, loader first
//================================================
`timescale 1ns/1ps

module mem_slot_arbiter
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset_n,
	mem_slot_if.arbiter ld,
	mem_slot_if.arbiter tp,
	input  logic        mem_slot_i,
	output logic        mem_ce_o,
	output logic        mem_we_o,
	output addr_t       mem_addr_o,
	output byte_t       mem_wdata_o,
	input  byte_t       mem_rdata_i
);

	logic  slot_d;
	logic  slot_fall;
	logic  slot_end;
	logic  grant_ld;
	logic  grant_tp;
	logic  own_tp;
	logic  rvalid_q;
	byte_t rdata_q;

	//================================================
	// Window events and grant
	//================================================

	assign slot_fall = slot_d && !mem_slot_i;
	// Second high sample closes the cycle
	assign slot_end  = slot_d && mem_slot_i;

	assign grant_ld = slot_fall && ld.req;
	assign grant_tp = slot_fall && !ld.req && tp.req;

	assign ld.ack = grant_ld;
	assign tp.ack = grant_tp;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_d   <= 1'b0;
			mem_ce_o <= 1'b0;
			mem_we_o <= 1'b0;
			own_tp   <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			slot_d   <= mem_slot_i;
			rvalid_q <= 1'b0;
			if (grant_ld || grant_tp) begin
				mem_ce_o <= 1'b1;
				mem_we_o <= grant_ld ? ld.we : tp.we;
				own_tp   <= grant_tp;
			end else if (slot_end && mem_ce_o) begin
				mem_ce_o <= 1'b0;
				mem_we_o <= 1'b0;
				rvalid_q <= !mem_we_o;
			end
		end
	end

	// Cycle address, write data and read capture
	always_ff @(posedge clk_sys) begin
		if (grant_ld) begin
			mem_addr_o  <= ld.addr;
			mem_wdata_o <= ld.wdata;
		end else if (grant_tp) begin
			mem_addr_o  <= tp.addr;
			mem_wdata_o <= tp.wdata;
		end
		if (slot_end && mem_ce_o && !mem_we_o)
			rdata_q <= mem_rdata_i;
	end

	assign ld.rvalid = rvalid_q && !own_tp;
	assign tp.rvalid = rvalid_q && own_tp;
	assign ld.rdata  = rdata_q;
	assign tp.rdata  = rdata_q;

endmodule

// ==== source/tape_reader.sv ====
//================================================
// Tape reader
// Plays a stored tape image back one byte per window
//================================================
`timescale 1ns/1ps

module tape_reader
	import loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_active_i,
	input  byte_t      dl_index_i,
	input  logic       dl_wr_i,
	input  addr_t      dl_addr_i,
	input  logic       tap_play_btn_i,
	input  logic       tap_unload_i,
	input  logic       tap_full_i,
	output logic       tap_byte_valid_o,
	output byte_t      tap_byte_o,
	output logic       tap_playing_o,
	mem_slot_if.client slot
);

	logic  tape_dl;
	logic  tap_reset;
	logic  btn_d;
	logic  play;
	logic  req_q;
	logic  busy;
	logic  drop_q;
	logic  rd_start;
	addr_t play_ptr;
	addr_t tap_end;
	addr_t rd_addr;

	assign tape_dl   = dl_active_i && (dl_index_i == IDX_TAP);
	assign tap_reset = tape_dl || tap_unload_i;

	// One read in flight at a time, none while the buffer is full
	assign rd_start = !tap_reset && play && (play_ptr < tap_end) && !tap_full_i
		&& !req_q && !busy;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			btn_d            <= 1'b0;
			play             <= 1'b0;
			req_q            <= 1'b0;
			busy             <= 1'b0;
			drop_q           <= 1'b0;
			play_ptr         <= '0;
			tap_end          <= '0;
			tap_byte_valid_o <= 1'b0;
		end else begin
			btn_d            <= tap_play_btn_i;
			tap_byte_valid_o <= 1'b0;

			if (slot.ack) begin
				req_q <= 1'b0;
				busy  <= 1'b1;
			end

			if (slot.rvalid) begin
				busy   <= 1'b0;
				drop_q <= 1'b0;
				if (!drop_q && !tap_reset) begin
					play_ptr         <= play_ptr + addr_t'(1);
					tap_byte_valid_o <= 1'b1;
				end
			end

			if (tap_reset) begin
				play_ptr <= '0;
				play     <= tape_dl;
				// Extent runs one byte past the last offset
				if (tape_dl && dl_wr_i)
					tap_end <= dl_addr_i + addr_t'(2);
				else if (!tape_dl)
					tap_end <= '0;
				// Read already on its way belongs to the old tape
				if (req_q || (busy && !slot.rvalid))
					drop_q <= 1'b1;
			end else begin
				if (!btn_d && tap_play_btn_i)
					play <= ~play;
				if (rd_start)
					req_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_start)
			rd_addr <= TAP_BASE + play_ptr;
		if (slot.rvalid)
			tap_byte_o <= slot.rdata;
	end

	assign slot.req   = req_q;
	assign slot.we    = 1'b0;
	assign slot.addr  = rd_addr;
	assign slot.wdata = '0;

	assign tap_playing_o = play;

endmodule

// ==== source/download_loader.sv ====
//================================================
// Download loader
// Turns program and tape downloads into memory writes
//================================================
`timescale 1ns/1ps

module download_loader
	import loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_n,

	// Host download stream
	input  logic       dl_active_i,
	input  byte_t      dl_index_i,
	input  logic       dl_wr_i,
	input  addr_t      dl_addr_i,
	input  byte_t      dl_data_i,
	output logic       dl_wait_o,

	mem_slot_if.client slot
);

	logic  is_prg;
	logic  is_tap;
	logic  byte_stb;
	logic  hdr_lo;
	logic  hdr_hi;
	logic  data_stb;
	logic  pending;
	addr_t load_addr;
	byte_t wr_data;

	//================================================
	// Stream decode
	//================================================

	// Top two index bits select other program variants
	assign is_prg = (dl_index_i[5:0] == IDX_PRG[5:0]) && (dl_index_i[7:6] == 2'b00);
	assign is_tap = (dl_index_i == IDX_TAP);

	assign byte_stb = dl_active_i && dl_wr_i && (is_prg || is_tap);

	// Load address bytes of a program image
	assign hdr_lo = is_prg && (dl_addr_i == '0);
	assign hdr_hi = is_prg && (dl_addr_i == addr_t'(PRG_HDR_LEN - 1));

	// Everything past the header is payload
	assign data_stb = byte_stb && (is_tap || (dl_addr_i >= addr_t'(PRG_HDR_LEN)));

	//================================================
	// Load address and pending write
	//================================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			pending   <= 1'b0;
			load_addr <= '0;
		end else begin
			if (slot.ack) begin
				pending   <= 1'b0;
				load_addr <= load_addr + addr_t'(1);
			end

			if (byte_stb && hdr_lo)
				load_addr <= addr_t'(dl_data_i);
			if (byte_stb && hdr_hi)
				load_addr[15:8] <= dl_data_i;

			// Tape starts over at the fixed base
			if (byte_stb && is_tap && (dl_addr_i == '0))
				load_addr <= TAP_BASE;

			if (data_stb)
				pending <= 1'b1;
		end
	end

	// Write data for the next slot
	always_ff @(posedge clk_sys) begin
		if (data_stb)
			wr_data <= dl_data_i;
	end

	assign slot.req   = pending;
	assign slot.we    = 1'b1;
	assign slot.addr  = load_addr;
	assign slot.wdata = wr_data;

	// Host holds off while a write is waiting for its slot
	assign dl_wait_o = pending;

endmodule

// ==== source/mem_slot_if.sv ====
//================================================
// Memory window client port
// Request side from a client, ack and read data back
//================================================
`timescale 1ns/1ps

interface mem_slot_if import loader_pkg::*; ();

	// Client request, held until ack
	logic  req;
	logic  we;
	addr_t addr;
	byte_t wdata;

	// Arbiter response pulses
	logic  ack;
	logic  rvalid;
	byte_t rdata;

	modport client (
		output req, we, addr, wdata,
		input  ack, rvalid, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output ack, rvalid, rdata
	);

endinterface

// ==== source/loader_pkg.sv ====
//================================================
// Media loader shared definitions
// Memory widths, download image indices, tape base
//================================================
package loader_pkg;

	//================================================
	// Memory geometry
	//================================================

	localparam int ADDR_W = 25;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;

	//================================================
	// Download images
	//================================================

	// Program image, recognised on the low six index bits
	localparam byte_t IDX_PRG = 8'd4;

	// Tape image
	localparam byte_t IDX_TAP = 8'd6;

	// Load address bytes at the start of a program image
	localparam int PRG_HDR_LEN = 2;

	// Tape images live above the 2 MB mark
	localparam addr_t TAP_BASE = 25'h200000;

endpackage
